//--- sms_pkg.sv
// cartridge handling shared definitions
// widths, counts, payload types and handshake structs of the console top level
package sms_pkg;

    // ============================================================
    // sizes and counts
    // ============================================================
    localparam int ROM_AW        = 22;
    localparam int HDR_BYTES     = 512;
    localparam int CE_PERIOD     = 30;
    localparam int RESET_HOLD_CE = 64;
    localparam int BK_SECTORS    = 16;
    localparam int SECTOR_AW     = 9;
    localparam int BK_AW         = 13;

    // phase counter and hold counter widths
    localparam int CE_CW   = $clog2(CE_PERIOD);
    localparam int HOLD_CW = $clog2(RESET_HOLD_CE + 1);

    // ============================================================
    // plain vector types
    // ============================================================
    typedef logic [ROM_AW-1:0] rom_addr_t;
    typedef logic [7:0]        byte_t;
    typedef logic [BK_AW-1:0]  bk_addr_t;
    typedef logic [31:0]       lba_t;

    // clock enables, one bit each
    typedef struct packed {
        logic cpu_p;
        logic cpu_n;
        logic vdp;
        logic pix;
        logic sp;
    } ce_t;

    // toggle write request towards ROM memory
    typedef struct packed {
        logic      req;
        rom_addr_t addr;
        byte_t     data;
    } rom_wr_t;

    // sector request to the SD side
    typedef struct packed {
        logic rd;
        logic wr;
        lba_t lba;
    } sd_req_t;

    // core access into backup RAM
    typedef struct packed {
        bk_addr_t addr;
        logic     we;
        byte_t    wdata;
    } nvram_port_t;

    // backup sequencer states
    typedef enum logic {
        BK_IDLE,
        BK_XFER
    } bk_state_e;

endpackage

//--- sms_clock_enables.sv
// clock enable generator
// one 30 clock phase cycle gives the cpu, vdp, pixel and sprite enables
`timescale 1ns/1ps

module sms_clock_enables import sms_pkg::*; (
    input  logic clk_sys,
    input  logic arst_n_i,
    output ce_t  ce_o
);

    logic [CE_CW-1:0] phase_q;
    ce_t              ce_q;
    ce_t              ce_next;

    // decode of the current phase
    always_comb begin
        ce_next    = '0;
        // div 2
        ce_next.sp = phase_q[0];
        case (phase_q)
            2, 17: begin
                ce_next.cpu_n = 1'b1;
            end
            4, 14: begin
                ce_next.vdp = 1'b1;
            end
            9, 24: begin
                // cpu rising phase, pixel only on 9
                ce_next.cpu_p = 1'b1;
                ce_next.vdp   = 1'b1;
                ce_next.pix   = (phase_q == 9);
            end
            19, 29: begin
                ce_next.vdp = 1'b1;
                ce_next.pix = 1'b1;
            end
            default: begin
                ce_next.vdp = 1'b0;
            end
        endcase
    end

    // phase counter, wraps at end of period
    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_q <= '0;
            ce_q    <= '0;
        end else begin
            ce_q <= ce_next;
            if (phase_q == CE_CW'(CE_PERIOD - 1)) begin
                phase_q <= '0;
            end else begin
                phase_q <= phase_q + 1'b1;
            end
        end
    end

    assign ce_o = ce_q;

    // both cpu phases in one cycle would clock the Z80 twice
    a_cpu_phases: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        !(ce_o.cpu_p && ce_o.cpu_n));

endmodule

//--- sms_rom_loader.sv
// ROM download loader
// forwards host bytes to memory with a toggle handshake, builds the mirror mask
// and strips a 512 byte copier header from core reads
`timescale 1ns/1ps

module sms_rom_loader import sms_pkg::*; (
    input  logic      clk_sys,
    input  logic      arst_n_i,
    // host download stream
    input  logic      dl_active_i,
    input  logic      dl_wr_i,
    input  rom_addr_t dl_addr_i,
    input  byte_t     dl_data_i,
    output logic      dl_wait_o,
    // memory write port
    output rom_wr_t   rom_wr_o,
    input  logic      rom_wr_ack_i,
    // core read path
    input  rom_addr_t core_rom_addr_i,
    output rom_addr_t rom_rd_addr_o
);

    logic      dl_q;
    logic      dl_start;
    logic      req_q;
    logic      wait_q;
    logic      hdr_q;
    rom_addr_t mask_q;
    rom_addr_t mask_next;
    rom_addr_t addr_q;
    byte_t     data_q;

    // ============================================================
    // download side
    // ============================================================
    assign dl_start = dl_active_i && !dl_q;

    // new download starts from an empty mask
    // every written address widens it
    always_comb begin
        mask_next = dl_start ? '0 : mask_q;
        if (dl_wr_i) begin
            mask_next = mask_next | dl_addr_i;
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dl_q   <= 1'b0;
            req_q  <= 1'b0;
            wait_q <= 1'b0;
            hdr_q  <= 1'b0;
            mask_q <= '0;
        end else begin
            dl_q   <= dl_active_i;
            mask_q <= mask_next;
            if (dl_wr_i) begin
                // flip request, stall host until memory catches up
                req_q  <= !req_q;
                wait_q <= 1'b1;
                // header present when image ends on a 512 byte boundary
                hdr_q  <= (dl_addr_i[9:0] == 10'h1FF);
            end else if (wait_q && (req_q == rom_wr_ack_i)) begin
                wait_q <= 1'b0;
            end
        end
    end

    // payload of the pending write
    always_ff @(posedge clk_sys) begin
        if (dl_wr_i) begin
            addr_q <= dl_addr_i;
            data_q <= dl_data_i;
        end
    end

    assign dl_wait_o = wait_q;
    assign rom_wr_o  = '{req: req_q, addr: addr_q, data: data_q};

    // ============================================================
    // read side
    // ============================================================
    // small carts mirror across the space, header offset skipped
    assign rom_rd_addr_o = (core_rom_addr_i & mask_q)
                         + (hdr_q ? rom_addr_t'(HDR_BYTES) : rom_addr_t'(0));

    // host must hold off while a byte is still in flight
    a_no_strobe_in_wait: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        dl_wr_i |-> !dl_wait_o);

endmodule

//--- sms_reset_ctrl.sv
// console reset controller
// merges reset sources and keeps reset asserted for a number of cpu enables
// after power up or a download
`timescale 1ns/1ps

module sms_reset_ctrl import sms_pkg::*; (
    input  logic clk_sys,
    input  logic arst_n_i,
    input  logic ce_cpu_i,
    input  logic user_reset_i,
    input  logic dl_active_i,
    input  logic bk_reset_i,
    output logic core_reset_o
);

    logic [HOLD_CW-1:0] hold_q;
    logic               hold_busy;
    logic               reset_q;

    assign hold_busy = (hold_q != '0);

    // hold counter
    // loaded from reset on, so power up also gets the hold
    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_q <= HOLD_CW'(RESET_HOLD_CE);
        end else if (dl_active_i) begin
            hold_q <= HOLD_CW'(RESET_HOLD_CE);
        end else if (ce_cpu_i && hold_busy) begin
            // counts in cpu cycles, not clk_sys
            hold_q <= hold_q - 1'b1;
        end
    end

    // registered reset to the core
    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reset_q <= 1'b1;
        end else begin
            reset_q <= user_reset_i | dl_active_i | bk_reset_i | hold_busy;
        end
    end

    assign core_reset_o = reset_q;

endmodule

//--- sms_backup_seq.sv
// battery backup sequencer
// moves the 8 KiB backup RAM to or from the SD image as 16 sectors of 512 bytes
`timescale 1ns/1ps

module sms_backup_seq import sms_pkg::*; (
    input  logic    clk_sys,
    input  logic    arst_n_i,
    input  logic    dl_active_i,
    // image control
    input  logic    img_mounted_i,
    input  lba_t    img_size_i,
    input  logic    save_i,
    // sector requests
    output sd_req_t sd_o,
    input  logic    sd_ack_i,
    // pulse after a completed load
    output logic    bk_reset_o
);

    bk_state_e state_q;
    sd_req_t   sd_q;
    logic      dl_q;
    logic      mounted_q;
    logic      save_q;
    logic      load_q;
    logic      ack_q;
    logic      bk_ena_q;
    logic      bk_load_q;
    logic      bk_reset_q;

    // edge detects
    logic dl_rise;
    logic mount_rise;
    logic save_rise;
    logic load_rise;
    logic ack_rise;
    logic ack_fall;
    logic last_sector;

    assign dl_rise     = dl_active_i && !dl_q;
    assign mount_rise  = img_mounted_i && !mounted_q;
    assign save_rise   = save_i && !save_q;
    assign load_rise   = bk_load_q && !load_q;
    assign ack_rise    = sd_ack_i && !ack_q;
    assign ack_fall    = !sd_ack_i && ack_q;
    assign last_sector = (sd_q.lba == lba_t'(BK_SECTORS - 1));

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= BK_IDLE;
            sd_q       <= '0;
            dl_q       <= 1'b0;
            mounted_q  <= 1'b0;
            save_q     <= 1'b0;
            load_q     <= 1'b0;
            ack_q      <= 1'b0;
            bk_ena_q   <= 1'b0;
            bk_load_q  <= 1'b0;
            bk_reset_q <= 1'b0;
        end else begin
            dl_q       <= dl_active_i;
            mounted_q  <= img_mounted_i;
            save_q     <= save_i;
            load_q     <= bk_load_q;
            ack_q      <= sd_ack_i;
            bk_reset_q <= 1'b0;

            // new cartridge invalidates the mounted save
            if (dl_rise) begin
                bk_ena_q <= 1'b0;
            end
            // empty image means nothing to load
            if (mount_rise && (img_size_i != '0)) begin
                bk_ena_q  <= 1'b1;
                bk_load_q <= 1'b1;
            end

            // request accepted
            if (ack_rise) begin
                sd_q.rd <= 1'b0;
                sd_q.wr <= 1'b0;
            end

            case (state_q)
                BK_IDLE: begin
                    if (bk_ena_q && (load_rise || save_rise)) begin
                        state_q  <= BK_XFER;
                        sd_q.lba <= '0;
                        sd_q.rd  <= bk_load_q;
                        sd_q.wr  <= !bk_load_q;
                    end
                end
                BK_XFER: begin
                    // sector done on ack fall
                    if (ack_fall) begin
                        if (last_sector) begin
                            // restart core so it sees loaded RAM
                            bk_reset_q <= bk_load_q;
                            bk_load_q  <= 1'b0;
                            state_q    <= BK_IDLE;
                        end else begin
                            sd_q.lba <= sd_q.lba + 1'b1;
                            sd_q.rd  <= bk_load_q;
                            sd_q.wr  <= !bk_load_q;
                        end
                    end
                end
                default: begin
                    state_q <= BK_IDLE;
                end
            endcase
        end
    end

    assign sd_o       = sd_q;
    assign bk_reset_o = bk_reset_q;

    // one direction per transfer
    a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        !(sd_o.rd && sd_o.wr));

endmodule

//--- sms_backup_ram.sv
// backup RAM, 8 KiB true dual port
// port A belongs to the core, port B to the SD sector buffer
`timescale 1ns/1ps

module sms_backup_ram import sms_pkg::*; (
    input  logic                 clk_sys,
    // core port
    input  nvram_port_t          nvram_i,
    output byte_t                nvram_rdata_o,
    // SD buffer port
    input  lba_t                 sd_lba_i,
    input  logic                 sd_ack_i,
    input  logic [SECTOR_AW-1:0] sd_buff_addr_i,
    input  logic                 sd_buff_wr_i,
    input  byte_t                sd_buff_dout_i,
    output byte_t                sd_buff_din_o
);

    byte_t    mem [0:(2**BK_AW)-1];
    bk_addr_t addr_b;
    logic     we_b;
    byte_t    rdata_a_q;
    byte_t    rdata_b_q;

    // sector number picks the 512 byte slice
    assign addr_b = {sd_lba_i[BK_AW-SECTOR_AW-1:0], sd_buff_addr_i};
    // buffer strobes outside a transfer are ignored
    assign we_b   = sd_buff_wr_i && sd_ack_i;

    // both ports, one cycle read
    always_ff @(posedge clk_sys) begin
        if (nvram_i.we) begin
            mem[nvram_i.addr] <= nvram_i.wdata;
        end
        if (we_b) begin
            mem[addr_b] <= sd_buff_dout_i;
        end
        rdata_a_q <= mem[nvram_i.addr];
        rdata_b_q <= mem[addr_b];
    end

    assign nvram_rdata_o = rdata_a_q;
    assign sd_buff_din_o = rdata_b_q;

endmodule

//--- sms_cart_top.sv
// cartridge handling top level
// clock enables, ROM download, core reset and battery backup
`timescale 1ns/1ps

module sms_cart_top import sms_pkg::*; (
    input  logic                 clk_sys,
    input  logic                 arst_n_i,
    // download stream
    input  logic                 dl_active_i,
    input  logic                 dl_wr_i,
    input  rom_addr_t            dl_addr_i,
    input  byte_t                dl_data_i,
    output logic                 dl_wait_o,
    // ROM memory
    output rom_wr_t              rom_wr_o,
    input  logic                 rom_wr_ack_i,
    input  rom_addr_t            core_rom_addr_i,
    output rom_addr_t            rom_rd_addr_o,
    // core control
    input  logic                 user_reset_i,
    output ce_t                  ce_o,
    output logic                 core_reset_o,
    // backup RAM, core side
    input  nvram_port_t          nvram_i,
    output byte_t                nvram_rdata_o,
    // SD side
    input  logic                 img_mounted_i,
    input  lba_t                 img_size_i,
    input  logic                 save_i,
    output sd_req_t              sd_o,
    input  logic                 sd_ack_i,
    input  logic [SECTOR_AW-1:0] sd_buff_addr_i,
    input  logic                 sd_buff_wr_i,
    input  byte_t                sd_buff_dout_i,
    output byte_t                sd_buff_din_o
);

    // load complete, restart core
    logic bk_reset;

    // ============================================================
    // timing and reset
    // ============================================================
    sms_clock_enables u_ce (
        .clk_sys  (clk_sys),
        .arst_n_i (arst_n_i),
        .ce_o     (ce_o)
    );

    sms_reset_ctrl u_rst (
        .clk_sys      (clk_sys),
        .arst_n_i     (arst_n_i),
        .ce_cpu_i     (ce_o.cpu_p),
        .user_reset_i (user_reset_i),
        .dl_active_i  (dl_active_i),
        .bk_reset_i   (bk_reset),
        .core_reset_o (core_reset_o)
    );

    // ============================================================
    // cartridge ROM
    // ============================================================
    sms_rom_loader u_loader (
        .clk_sys         (clk_sys),
        .arst_n_i        (arst_n_i),
        .dl_active_i     (dl_active_i),
        .dl_wr_i         (dl_wr_i),
        .dl_addr_i       (dl_addr_i),
        .dl_data_i       (dl_data_i),
        .dl_wait_o       (dl_wait_o),
        .rom_wr_o        (rom_wr_o),
        .rom_wr_ack_i    (rom_wr_ack_i),
        .core_rom_addr_i (core_rom_addr_i),
        .rom_rd_addr_o   (rom_rd_addr_o)
    );

    // ============================================================
    // battery backup
    // ============================================================
    sms_backup_seq u_bkseq (
        .clk_sys       (clk_sys),
        .arst_n_i      (arst_n_i),
        .dl_active_i   (dl_active_i),
        .img_mounted_i (img_mounted_i),
        .img_size_i    (img_size_i),
        .save_i        (save_i),
        .sd_o          (sd_o),
        .sd_ack_i      (sd_ack_i),
        .bk_reset_o    (bk_reset)
    );

    // sector buffer addressed by current lba
    sms_backup_ram u_bkram (
        .clk_sys        (clk_sys),
        .nvram_i        (nvram_i),
        .nvram_rdata_o  (nvram_rdata_o),
        .sd_lba_i       (sd_o.lba),
        .sd_ack_i       (sd_ack_i),
        .sd_buff_addr_i (sd_buff_addr_i),
        .sd_buff_wr_i   (sd_buff_wr_i),
        .sd_buff_dout_i (sd_buff_dout_i),
        .sd_buff_din_o  (sd_buff_din_o)
    );

endmodule

//--- tb_sms_cart.sv
// testbench for the cartridge handling top level
// vector driven ROM download, reset and backup checks with SDRAM and SD card models
`timescale 1ns/1ps

module tb_sms_cart import sms_pkg::*; ();

    // test index per reported line
    localparam int T_CE     = 0;
    localparam int T_DL     = 1;
    localparam int T_XL     = 2;
    localparam int T_RESET  = 3;
    localparam int T_USER   = 4;
    localparam int T_LOAD   = 5;
    localparam int T_SAVE   = 6;
    localparam int N_TESTS  = 7;
    localparam int VEC_MAX  = 64;
    localparam int WAIT_MAX = 20000;

    // byte changed through the core port before the save
    localparam bk_addr_t MOD_ADDR = 13'h0A37;
    localparam byte_t    MOD_DATA = 8'hC3;

    logic                 clk_sys = 1'b0;
    logic                 arst_n_i;
    logic                 dl_active_i;
    logic                 dl_wr_i;
    rom_addr_t            dl_addr_i;
    byte_t                dl_data_i;
    logic                 dl_wait_o;
    rom_wr_t              rom_wr_o;
    logic                 rom_wr_ack_i = 1'b0;
    rom_addr_t            core_rom_addr_i;
    rom_addr_t            rom_rd_addr_o;
    logic                 user_reset_i;
    ce_t                  ce_o;
    logic                 core_reset_o;
    nvram_port_t          nvram_i;
    byte_t                nvram_rdata_o;
    logic                 img_mounted_i;
    lba_t                 img_size_i;
    logic                 save_i;
    sd_req_t              sd_o;
    logic                 sd_ack_i = 1'b0;
    logic [SECTOR_AW-1:0] sd_buff_addr_i = '0;
    logic                 sd_buff_wr_i = 1'b0;
    byte_t                sd_buff_dout_i = '0;
    byte_t                sd_buff_din_o;

    integer      seed = 32'h2c40658a;
    int          errs [N_TESTS];
    int          sectors_done;
    logic [31:0] vec_mem [0:3*VEC_MAX-1];

    // what the models saw
    rom_addr_t rom_addr_log [$];
    byte_t     rom_data_log [$];
    lba_t      sd_lba_log [$];
    logic      sd_dir_log [$];

    sms_cart_top uut (.*);

    always #20 clk_sys = ~clk_sys;

    // ============================================================
    // helpers
    // ============================================================
    // 2 ns past the rising edge, drive point
    task automatic tick();
        @(posedge clk_sys);
        #2;
    endtask

    function automatic string test_name(input int t);
        case (t)
            T_CE:    return "clock_enables";
            T_DL:    return "download";
            T_XL:    return "translate";
            T_RESET: return "reset_hold";
            T_USER:  return "user_reset";
            T_LOAD:  return "backup_load";
            default: return "backup_save";
        endcase
    endfunction

    // SD image content, low byte of the linear address xor 5A
    function automatic byte_t sd_pattern(input lba_t lba, input int unsigned off);
        logic [31:0] lin;
        lin = lba * 512 + off;
        return lin[7:0] ^ 8'h5A;
    endfunction

    task automatic check_val(input int t, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h",
                     test_name(t), what, exp, act);
            errs[t]++;
        end
    endtask

    task automatic report_fail(input int t, input string msg);
        $display("ERROR in %s: %s", test_name(t), msg);
        errs[t]++;
    endtask

    task automatic end_test(input int t);
        $display("%-14s %s, %0d errors", test_name(t), (errs[t] == 0) ? "ok" : "FAIL", errs[t]);
    endtask

    // ============================================================
    // SDRAM model, ack follows req after 1 to 8 cycles
    // ============================================================
    always begin : sdram_model
        int unsigned delay;
        @(posedge clk_sys);
        #1;
        if (arst_n_i && (rom_wr_o.req != rom_wr_ack_i)) begin
            rom_addr_log.push_back(rom_wr_o.addr);
            rom_data_log.push_back(rom_wr_o.data);
            delay = 1 + ($unsigned($random(seed)) % 8);
            repeat (delay) @(posedge clk_sys);
            #2 rom_wr_ack_i = rom_wr_o.req;
        end
    end

    // ============================================================
    // SD card model, one sector per request
    // ============================================================
    always begin : sd_model
        lba_t        lba_cur;
        logic        is_wr;
        int          off;
        logic [31:0] lin;
        tick();
        if (arst_n_i && (sd_o.rd || sd_o.wr)) begin
            lba_cur = sd_o.lba;
            is_wr   = sd_o.wr;
            sd_lba_log.push_back(lba_cur);
            sd_dir_log.push_back(is_wr);
            repeat (3) @(posedge clk_sys);
            #2 sd_ack_i = 1'b1;
            for (off = 0; off < 512; off++) begin
                sd_buff_addr_i = off[SECTOR_AW-1:0];
                sd_buff_wr_i   = !is_wr;
                sd_buff_dout_i = sd_pattern(lba_cur, off);
                tick();
                // save data, one cycle read latency
                if (is_wr) begin
                    lin = lba_cur * 512 + off;
                    check_val(T_SAVE, "sd_buff_din",
                              (lin == MOD_ADDR) ? MOD_DATA : sd_pattern(lba_cur, off),
                              sd_buff_din_o);
                end
            end
            sd_buff_wr_i = 1'b0;
            sd_ack_i     = 1'b0;
            sectors_done++;
        end
    end

    // ============================================================
    // download and sector tasks
    // ============================================================
    task automatic send_byte(input rom_addr_t a, input byte_t d);
        int n;
        dl_addr_i = a;
        dl_data_i = d;
        dl_wr_i   = 1'b1;
        tick();
        dl_wr_i = 1'b0;
        n = 0;
        // host stalls on dl_wait_o
        while (dl_wait_o && (n < 100)) begin
            assert (core_reset_o) else report_fail(T_RESET, "core reset low during download");
            tick();
            n++;
        end
        assert (!dl_wait_o) else report_fail(T_DL, "timeout waiting for dl_wait_o to fall");
        assert (rom_addr_log.size() == 1) else report_fail(T_DL, "byte not seen once on rom_wr_o");
        if (rom_addr_log.size() != 0) begin
            check_val(T_DL, "rom_wr addr", a, rom_addr_log.pop_front());
            check_val(T_DL, "rom_wr data", d, rom_data_log.pop_front());
        end
    endtask

    task automatic check_translate(input rom_addr_t core_a, input rom_addr_t exp_a);
        core_rom_addr_i = core_a;
        // combinational path, settle well before the edge
        #5;
        check_val(T_XL, "rom_rd_addr", exp_a, rom_rd_addr_o);
    endtask

    // end of download, reset must stay for the cpu hold period
    task automatic finish_download();
        int n;
        dl_active_i = 1'b0;
        tick();
        n = 0;
        while (core_reset_o && (n < RESET_HOLD_CE * 15 + 40)) begin
            tick();
            n++;
        end
        assert (!core_reset_o) else report_fail(T_RESET, "core reset not released after download");
        assert (n >= (RESET_HOLD_CE - 1) * 15) else report_fail(T_RESET, "core reset released early");
        assert (rom_addr_log.size() == 0) else report_fail(T_DL, "extra bytes on rom_wr_o");
    endtask

    task automatic check_sectors(input int t, input logic exp_wr);
        int s;
        assert (sd_lba_log.size() == BK_SECTORS) else report_fail(t, "wrong sector request count");
        for (s = 0; s < sd_lba_log.size(); s++) begin
            check_val(t, "sector lba", s, sd_lba_log[s]);
            check_val(t, "sector direction", exp_wr, sd_dir_log[s]);
        end
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin : main
        int          i;
        int          k;
        int          n;
        int          total;
        int          passed;
        int          cnt_sp;
        int          cnt_vdp;
        int          cnt_pix;
        int          cnt_cp;
        int          cnt_cn;
        logic [31:0] kind;
        logic        in_dl;
        bk_addr_t    a;

        arst_n_i        = 1'b0;
        dl_active_i     = 1'b0;
        dl_wr_i         = 1'b0;
        dl_addr_i       = '0;
        dl_data_i       = '0;
        core_rom_addr_i = '0;
        user_reset_i    = 1'b0;
        nvram_i         = '0;
        img_mounted_i   = 1'b0;
        img_size_i      = '0;
        save_i          = 1'b0;
        sectors_done    = 0;
        for (k = 0; k < N_TESTS; k++) begin
            errs[k] = 0;
        end
        $readmemh("sms_cart_vectors.txt", vec_mem);

        repeat (3) @(posedge clk_sys);
        #2 arst_n_i = 1'b1;

        // enables over ten full phase cycles
        cnt_sp  = 0;
        cnt_vdp = 0;
        cnt_pix = 0;
        cnt_cp  = 0;
        cnt_cn  = 0;
        for (k = 0; k < 300; k++) begin
            tick();
            cnt_sp  += int'(ce_o.sp);
            cnt_vdp += int'(ce_o.vdp);
            cnt_pix += int'(ce_o.pix);
            cnt_cp  += int'(ce_o.cpu_p);
            cnt_cn  += int'(ce_o.cpu_n);
            assert (!(ce_o.cpu_p && ce_o.cpu_n)) else report_fail(T_CE, "cpu_p and cpu_n together");
        end
        check_val(T_CE, "sp pulses", 150, cnt_sp);
        check_val(T_CE, "vdp pulses", 60, cnt_vdp);
        check_val(T_CE, "pix pulses", 30, cnt_pix);
        check_val(T_CE, "cpu_p pulses", 20, cnt_cp);
        check_val(T_CE, "cpu_n pulses", 20, cnt_cn);
        end_test(T_CE);

        // vector file, a run of download lines forms one download
        in_dl = 1'b0;
        i     = 0;
        kind  = '0;
        while ((kind == 0 || kind == 1) && (i < VEC_MAX)) begin
            kind = vec_mem[3*i];
            if (in_dl && (kind != 0)) begin
                finish_download();
                in_dl = 1'b0;
            end
            if (kind == 0) begin
                if (!in_dl) begin
                    dl_active_i = 1'b1;
                    tick();
                    in_dl = 1'b1;
                end
                send_byte(rom_addr_t'(vec_mem[3*i+1]), byte_t'(vec_mem[3*i+2]));
            end else if (kind == 1) begin
                check_translate(rom_addr_t'(vec_mem[3*i+1]), rom_addr_t'(vec_mem[3*i+2]));
                tick();
            end
            i++;
        end
        assert (kind == 2) else report_fail(T_DL, "vector file has no end line");
        end_test(T_DL);
        end_test(T_XL);
        end_test(T_RESET);

        // user reset pulse
        user_reset_i = 1'b1;
        tick();
        user_reset_i = 1'b0;
        assert (core_reset_o) else report_fail(T_USER, "user reset did not raise core reset");
        n = 0;
        while (core_reset_o && (n < 10)) begin
            tick();
            n++;
        end
        assert (!core_reset_o) else report_fail(T_USER, "core reset stuck after user reset");
        end_test(T_USER);

        // mount loads all sectors, then restarts the core
        sd_lba_log.delete();
        sd_dir_log.delete();
        img_size_i    = 32'd16;
        img_mounted_i = 1'b1;
        tick();
        img_mounted_i = 1'b0;
        n = 0;
        while (!core_reset_o && (n < WAIT_MAX)) begin
            tick();
            n++;
        end
        assert (core_reset_o) else report_fail(T_LOAD, "no core reset after backup load");
        check_sectors(T_LOAD, 1'b0);
        tick();
        assert (!core_reset_o) else report_fail(T_LOAD, "core reset after load is not one pulse");
        for (k = 0; k < 16; k++) begin
            a = bk_addr_t'(k * 523 + 7);
            nvram_i.addr = a;
            tick();
            check_val(T_LOAD, "nvram_rdata",
                      sd_pattern(lba_t'(a >> SECTOR_AW), a[SECTOR_AW-1:0]), nvram_rdata_o);
        end
        end_test(T_LOAD);

        // core writes one byte, then save
        nvram_i = '{addr: MOD_ADDR, we: 1'b1, wdata: MOD_DATA};
        tick();
        nvram_i.we = 1'b0;
        sd_lba_log.delete();
        sd_dir_log.delete();
        sectors_done = 0;
        save_i = 1'b1;
        tick();
        save_i = 1'b0;
        n = 0;
        while ((sectors_done < BK_SECTORS) && (n < WAIT_MAX)) begin
            tick();
            n++;
        end
        assert (sectors_done == BK_SECTORS) else report_fail(T_SAVE, "backup save did not finish");
        check_sectors(T_SAVE, 1'b1);
        end_test(T_SAVE);

        total  = 0;
        passed = 0;
        for (k = 0; k < N_TESTS; k++) begin
            total += errs[k];
            if (errs[k] == 0) begin
                passed++;
            end
        end
        $display("tests: %0d run, %0d passed, %0d failed, %0d errors",
                 N_TESTS, passed, N_TESTS - passed, total);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sms_cart_vectors.txt
// columns, hex: kind address value
// kind 0 download byte (addr, data), kind 1 translate (core addr, rom addr), kind 2 end
0 000000 f3
0 000001 ed
0 000002 56
0 000003 c3
0 001ffe 4d
0 001fff 21
1 002345 000345
1 3fffff 001fff
1 000010 000010
0 000000 00
0 000100 aa
0 0081fe 55
0 0081ff 99
1 000000 000200
1 001234 000234
1 3fffff 0083ff
1 008155 008355
2 000000 000000

//--- src.f
sms_pkg.sv
sms_clock_enables.sv
sms_rom_loader.sv
sms_reset_ctrl.sv
sms_backup_seq.sv
sms_backup_ram.sv
sms_cart_top.sv
tb_sms_cart.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cartridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_sms_cart -f src.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

exit 0
